// ==== cache_stage1.f ====
+incdir+source
source/cache_pkg.sv
source/cache_tag_store.sv
source/cache_meta_store.sv
source/cache_way_select.sv
source/cache_data_store.sv
source/cache_stage1.sv
verification/cache_stage1_chk.sv
verification/cache_stage1_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f cache_stage1.f --top-module cache_stage1_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcache_stage1_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// ==== verification/cache_stage1_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_stage1_tb;

    localparam int OP_READ = 1;
    localparam int OP_WRITE = 2;
    localparam int OP_FILL = 3;
    localparam int RST_CYCLES = 10;
    localparam int MAX_ROWS = 32;

    logic clk;
    logic rst_n;
    logic req_valid;
    logic req_write;
    cache_pkg::addr_t req_addr;
    cache_pkg::line_t req_data;
    cache_pkg::mask_t req_mask;
    logic fill_valid;
    cache_pkg::addr_t fill_addr;
    cache_pkg::line_t fill_line;
    logic mshr_full;
    logic resp_valid;
    logic hit;
    logic miss;
    logic stall;
    cache_pkg::line_t cache_line;
    cache_pkg::addr_t ext_addr;
    logic wb_valid;
    cache_pkg::addr_t wb_addr;

    // stimulus table, flags are {hit, miss, stall, wb_valid}
    int tb_op [MAX_ROWS];
    cache_pkg::addr_t tb_addr [MAX_ROWS];
    int tb_msel [MAX_ROWS];
    logic tb_full [MAX_ROWS];
    logic [3:0] tb_flags [MAX_ROWS];
    int n_rows = 0;
    int n_errors = 0;

    // reference model of the cache arrays
    cache_pkg::tag_t m_tag [`CACHE_SETS][`CACHE_WAYS];
    logic m_valid [`CACHE_SETS][`CACHE_WAYS];
    logic m_dirty [`CACHE_SETS][`CACHE_WAYS];
    int m_age [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::line_t m_line [`CACHE_SETS][`CACHE_WAYS];

    cache_pkg::line_t exp_line;
    cache_pkg::addr_t exp_ext;
    cache_pkg::addr_t exp_wb_addr;
    logic exp_wb;

    logic [15:0] lfsr = 16'd48389;

    cache_stage1 u_cache_stage1 (.*);

    bind cache_stage1 cache_stage1_chk u_chk (.clk, .rst_n, .req_valid, .fill_valid,
        .resp_valid, .hit, .miss, .stall);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_line(output cache_pkg::line_t l);
        for (int i = 0; i < `CACHE_LINE_BITS; i++) begin
            lfsr = lfsr_next(lfsr);
            l[i] = lfsr[0];
        end
    endtask

    function automatic cache_pkg::mask_t mask_for(input int sel);
        case (sel)
            1: return {8{16'h00ff}};
            2: return {{96{1'b0}}, {32{1'b1}}};
            default: return '1;
        endcase
    endfunction

    function automatic cache_pkg::addr_t addr_of(input cache_pkg::tag_t t,
            input cache_pkg::index_t i, input logic [`CACHE_INDEX_LSB-1:0] off);
        return {t, i, off};
    endfunction

    task automatic add_row(input int op, input cache_pkg::addr_t a, input int msel,
            input logic full, input logic [3:0] flags);
        tb_op[n_rows] = op;
        tb_addr[n_rows] = a;
        tb_msel[n_rows] = msel;
        tb_full[n_rows] = full;
        tb_flags[n_rows] = flags;
        n_rows++;
    endtask

    function automatic int find_way(input cache_pkg::index_t i, input cache_pkg::tag_t t);
        int w_hit;
        w_hit = -1;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[i][w] && m_tag[i][w] == t) begin
                w_hit = w;
            end
        end
        return w_hit;
    endfunction

    // lowest invalid way, else the lowest way with the oldest age
    function automatic int pick_victim(input cache_pkg::index_t i);
        int inv;
        int old;
        inv = -1;
        old = 0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!m_valid[i][w]) begin
                inv = w;
            end
            if (m_age[i][w] == `CACHE_WAYS - 1) begin
                old = w;
            end
        end
        return (inv >= 0) ? inv : old;
    endfunction

    // a way filled from invalid counts as the oldest
    task automatic touch_model(input cache_pkg::index_t i, input int w);
        int t_age;
        t_age = m_valid[i][w] ? m_age[i][w] : `CACHE_WAYS - 1;
        for (int v = 0; v < `CACHE_WAYS; v++) begin
            if (v != w && m_valid[i][v] && m_age[i][v] < t_age) begin
                m_age[i][v]++;
            end
        end
        m_age[i][w] = 0;
    endtask

    // expected values come from the model state before the update
    task automatic apply_row(input int k);
        int way;
        int vic;
        cache_pkg::index_t idx;
        cache_pkg::tag_t tag;
        cache_pkg::line_t data;
        cache_pkg::mask_t mask;
        idx = tb_addr[k][`CACHE_INDEX_LSB +: `CACHE_INDEX_BITS];
        tag = tb_addr[k][`CACHE_TAG_LSB +: `CACHE_TAG_BITS];
        mask = mask_for(tb_msel[k]);
        data = '0;
        if (tb_op[k] != OP_READ) begin
            random_line(data);
        end
        way = find_way(idx, tag);
        exp_ext = {tag, idx, {`CACHE_INDEX_LSB{1'b0}}};
        exp_line = '0;
        exp_wb = 1'b0;
        if (tb_op[k] == OP_FILL) begin
            vic = pick_victim(idx);
            exp_wb = m_valid[idx][vic] && m_dirty[idx][vic];
            exp_wb_addr = {m_tag[idx][vic], idx, {`CACHE_INDEX_LSB{1'b0}}};
            touch_model(idx, vic);
            m_tag[idx][vic] = tag;
            m_line[idx][vic] = data;
            m_valid[idx][vic] = 1'b1;
            m_dirty[idx][vic] = 1'b0;
        end else if (way >= 0) begin
            exp_line = m_line[idx][way];
            if (tb_op[k] == OP_WRITE) begin
                m_line[idx][way] = (m_line[idx][way] & ~mask) | (data & mask);
                m_dirty[idx][way] = 1'b1;
            end
            touch_model(idx, way);
        end
        req_valid <= (tb_op[k] != OP_FILL);
        req_write <= (tb_op[k] == OP_WRITE);
        req_addr <= tb_addr[k];
        req_data <= data;
        req_mask <= mask;
        fill_valid <= (tb_op[k] == OP_FILL);
        fill_addr <= tb_addr[k];
        fill_line <= data;
        mshr_full <= tb_full[k];
    endtask

    task automatic flag_error(input int k, input string what);
        $display("ERR %0t: row %0d, %s", $time, k, what);
        n_errors++;
    endtask

    initial begin
        logic is_req;
        rst_n <= 1'b0;
        req_valid <= 1'b0;
        req_write <= 1'b0;
        req_addr <= '0;
        req_data <= '0;
        req_mask <= '0;
        fill_valid <= 1'b0;
        fill_addr <= '0;
        fill_line <= '0;
        mshr_full <= 1'b0;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_tag[s][w] = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w] = 0;
                m_line[s][w] = '0;
            end
        end

        // miss after reset, then fill, hit, partial write and read back
        add_row(OP_READ, addr_of(8'h11, 2'd1, 5'h04), 0, 1'b0, 4'b0100);
        add_row(OP_FILL, addr_of(8'h11, 2'd1, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_READ, addr_of(8'h11, 2'd1, 5'h10), 0, 1'b0, 4'b1000);
        add_row(OP_WRITE, addr_of(8'h11, 2'd1, 5'h00), 1, 1'b0, 4'b1000);
        add_row(OP_READ, addr_of(8'h11, 2'd1, 5'h1f), 0, 1'b0, 4'b1000);
        // index 2: four fills, way 1 made dirty, evictions until it goes
        add_row(OP_FILL, addr_of(8'h20, 2'd2, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_FILL, addr_of(8'h21, 2'd2, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_FILL, addr_of(8'h22, 2'd2, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_FILL, addr_of(8'h23, 2'd2, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_WRITE, addr_of(8'h21, 2'd2, 5'h08), 2, 1'b0, 4'b1000);
        add_row(OP_FILL, addr_of(8'h24, 2'd2, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_READ, addr_of(8'h20, 2'd2, 5'h00), 0, 1'b0, 4'b0100);
        add_row(OP_FILL, addr_of(8'h25, 2'd2, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_FILL, addr_of(8'h26, 2'd2, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_FILL, addr_of(8'h27, 2'd2, 5'h00), 0, 1'b0, 4'b0001);
        add_row(OP_READ, addr_of(8'h21, 2'd2, 5'h08), 0, 1'b0, 4'b0100);
        // stall only on a miss
        add_row(OP_READ, addr_of(8'h40, 2'd0, 5'h00), 0, 1'b1, 4'b0110);
        add_row(OP_READ, addr_of(8'h11, 2'd1, 5'h00), 0, 1'b1, 4'b1000);
        // index 3: a read hit makes way 0 young, so way 1 is evicted next
        add_row(OP_FILL, addr_of(8'h30, 2'd3, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_FILL, addr_of(8'h31, 2'd3, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_FILL, addr_of(8'h32, 2'd3, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_FILL, addr_of(8'h33, 2'd3, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_READ, addr_of(8'h30, 2'd3, 5'h00), 0, 1'b0, 4'b1000);
        add_row(OP_FILL, addr_of(8'h34, 2'd3, 5'h00), 0, 1'b0, 4'b0000);
        add_row(OP_READ, addr_of(8'h31, 2'd3, 5'h00), 0, 1'b0, 4'b0100);
        add_row(OP_READ, addr_of(8'h30, 2'd3, 5'h00), 0, 1'b0, 4'b1000);

        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int k = 0; k < n_rows; k++) begin
            @(posedge clk);
            apply_row(k);
            @(posedge clk);
            req_valid <= 1'b0;
            fill_valid <= 1'b0;
            @(negedge clk);
            is_req = (tb_op[k] != OP_FILL);
            if (resp_valid !== is_req) begin
                flag_error(k, $sformatf("resp_valid %b, expected %b", resp_valid, is_req));
            end
            if ({hit, miss, stall, wb_valid} !== tb_flags[k]) begin
                flag_error(k, $sformatf("hit/miss/stall/wb %b, expected %b",
                    {hit, miss, stall, wb_valid}, tb_flags[k]));
            end
            if (is_req && cache_line !== exp_line) begin
                flag_error(k, $sformatf("cache_line %h, expected %h", cache_line, exp_line));
            end
            if (is_req && ext_addr !== exp_ext) begin
                flag_error(k, $sformatf("ext_addr %h, expected %h", ext_addr, exp_ext));
            end
            if (exp_wb && wb_addr !== exp_wb_addr) begin
                flag_error(k, $sformatf("wb_addr %h, expected %h", wb_addr, exp_wb_addr));
            end
        end

        @(posedge clk);
        n_errors = n_errors + u_cache_stage1.u_chk.fail_count;
        $display("rows %0d, errors %0d", n_rows, n_errors);
        if (n_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // three cycles per table row plus reset is well past the real run length
    initial begin
        #1;
        repeat (n_rows * 3 + RST_CYCLES) @(posedge clk);
        $display("timeout: table not finished after %0d cycles", n_rows * 3 + RST_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/cache_stage1_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_stage1_chk (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic fill_valid,
    input logic resp_valid,
    input logic hit,
    input logic miss,
    input logic stall
);

    // failed assertions so far
    int fail_count = 0;

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(req_valid && fill_valid))
        else begin
            $error("request and fill strobes high in the same cycle");
            fail_count++;
        end

    a_flags_with_resp: assert property (@(posedge clk) disable iff (!rst_n)
        (hit || miss) |-> resp_valid)
        else begin
            $error("hit or miss high without resp_valid");
            fail_count++;
        end

    a_hit_miss_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(hit && miss))
        else begin
            $error("hit and miss high together");
            fail_count++;
        end

    a_stall_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> miss)
        else begin
            $error("stall high without miss");
            fail_count++;
        end

    // response one cycle behind the request strobe
    a_resp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid == $past(req_valid))
        else begin
            $error("resp_valid does not follow req_valid by one cycle");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== source/cache_stage1.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_stage1 (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  logic                req_write,
    input  cache_pkg::addr_t    req_addr,
    input  cache_pkg::line_t    req_data,
    input  cache_pkg::mask_t    req_mask,
    input  logic                fill_valid,
    input  cache_pkg::addr_t    fill_addr,
    input  cache_pkg::line_t    fill_line,
    input  logic                mshr_full,
    output logic                resp_valid,
    output logic                hit,
    output logic                miss,
    output logic                stall,
    output cache_pkg::line_t    cache_line,
    output cache_pkg::addr_t    ext_addr,
    output logic                wb_valid,
    output cache_pkg::addr_t    wb_addr
);

    cache_pkg::addr_t sel_addr;
    cache_pkg::index_t index;
    cache_pkg::tag_t tag;

    cache_pkg::way_t hits;
    cache_pkg::way_t victim;
    cache_pkg::tag_t [`CACHE_WAYS-1:0] tags;
    logic [`CACHE_WAYS-1:0] valid;
    logic [`CACHE_WAYS-1:0] dirty;
    cache_pkg::age_t [`CACHE_WAYS-1:0] ages;
    cache_pkg::line_t [`CACHE_WAYS-1:0] lines;
    logic victim_dirty;

    logic req_hit;
    logic req_miss;
    logic write_hit;
    logic touch;
    cache_pkg::way_t touch_way;
    logic data_we;
    cache_pkg::mask_t data_mask;
    cache_pkg::line_t data_in;
    cache_pkg::line_t hit_line;
    cache_pkg::tag_t victim_tag;

    // fill and request never share a cycle
    assign sel_addr = fill_valid ? fill_addr : req_addr;
    assign index = sel_addr[`CACHE_INDEX_LSB +: `CACHE_INDEX_BITS];
    assign tag = sel_addr[`CACHE_TAG_LSB +: `CACHE_TAG_BITS];

    assign req_hit = req_valid && (|hits);
    assign req_miss = req_valid && !(|hits);
    assign write_hit = req_hit && req_write;

    assign touch = req_hit || fill_valid;
    assign touch_way = fill_valid ? victim : hits;
    assign data_we = write_hit || fill_valid;
    assign data_mask = fill_valid ? '1 : req_mask;
    assign data_in = fill_valid ? fill_line : req_data;

    cache_tag_store u_tag_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .index    (index),
        .tag_in   (tag),
        .tag_we   (fill_valid),
        .tag_way  (victim),
        .valid    (valid),
        .hits     (hits),
        .tags_out (tags)
    );

    cache_meta_store u_meta_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (index),
        .touch     (touch),
        .touch_way (touch_way),
        .set_dirty (write_hit),
        .fill      (fill_valid),
        .valid     (valid),
        .dirty     (dirty),
        .ages      (ages)
    );

    cache_way_select u_way_select (
        .valid        (valid),
        .dirty        (dirty),
        .ages         (ages),
        .victim       (victim),
        .victim_dirty (victim_dirty)
    );

    cache_data_store u_data_store (
        .clk       (clk),
        .index     (index),
        .write_way (touch_way),
        .write_en  (data_we),
        .mask      (data_mask),
        .data_in   (data_in),
        .lines_out (lines)
    );

    // one-hot muxes, hit_line stays zero on a miss
    always_comb begin
        hit_line = '0;
        victim_tag = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (hits[w]) begin
                hit_line = hit_line | lines[w];
            end
            if (victim[w]) begin
                victim_tag = victim_tag | tags[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            hit <= 1'b0;
            miss <= 1'b0;
            stall <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid;
            hit <= req_hit;
            miss <= req_miss;
            stall <= req_miss && mshr_full;
            wb_valid <= fill_valid && victim_dirty;
        end
    end

    // line read here is the one before this edge's write
    always_ff @(posedge clk) begin
        if (req_valid) begin
            cache_line <= hit_line;
            ext_addr <= {tag, index, {`CACHE_INDEX_LSB{1'b0}}};
        end
        if (fill_valid) begin
            wb_addr <= {victim_tag, index, {`CACHE_INDEX_LSB{1'b0}}};
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_data_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_data_store (
    input  logic                                clk,
    input  cache_pkg::index_t                   index,
    input  cache_pkg::way_t                     write_way,
    input  logic                                write_en,
    input  cache_pkg::mask_t                    mask,
    input  cache_pkg::line_t                    data_in,
    output cache_pkg::line_t [`CACHE_WAYS-1:0]  lines_out
);

    cache_pkg::line_t lines [`CACHE_SETS][`CACHE_WAYS];

    // bitwise merge, a fill comes in with every mask bit set
    always_ff @(posedge clk) begin
        if (write_en) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (write_way[w]) begin
                    lines[index][w] <= (lines[index][w] & ~mask) | (data_in & mask);
                end
            end
        end
    end

    // all ways of the set, the top level picks one
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            lines_out[w] = lines[index][w];
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_way_select.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_way_select (
    input  logic [`CACHE_WAYS-1:0]              valid,
    input  logic [`CACHE_WAYS-1:0]              dirty,
    input  cache_pkg::age_t [`CACHE_WAYS-1:0]   ages,
    output cache_pkg::way_t                     victim,
    output logic                                victim_dirty
);

    logic found;

    always_comb begin
        victim = '0;
        found = 1'b0;
        // first choice is the lowest invalid way
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!found && !valid[w]) begin
                victim[w] = 1'b1;
                found = 1'b1;
            end
        end
        // full set: the least recently used way
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!found && (ages[w] == '1)) begin
                victim[w] = 1'b1;
                found = 1'b1;
            end
        end
        victim_dirty = |(victim & valid & dirty);
    end

endmodule

`default_nettype wire

// ==== source/cache_meta_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_meta_store (
    input  logic                                clk,
    input  logic                                rst_n,
    input  cache_pkg::index_t                   index,
    input  logic                                touch,
    input  cache_pkg::way_t                     touch_way,
    input  logic                                set_dirty,
    input  logic                                fill,
    output logic [`CACHE_WAYS-1:0]              valid,
    output logic [`CACHE_WAYS-1:0]              dirty,
    output cache_pkg::age_t [`CACHE_WAYS-1:0]   ages
);

    logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] dirty_q [`CACHE_SETS];
    cache_pkg::age_t [`CACHE_WAYS-1:0] age_q [`CACHE_SETS];

    cache_pkg::age_t touch_age;

    // an invalid way being filled counts as oldest, so every valid way ages
    // and a set filled from empty ends up with ages 0..3
    always_comb begin
        touch_age = '1;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (touch_way[w] && valid_q[index][w]) begin
                touch_age = age_q[index][w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                age_q[s] <= '0;
            end
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (touch) begin
                    if (touch_way[w]) begin
                        age_q[index][w] <= '0;
                    end else if (valid_q[index][w] && (age_q[index][w] < touch_age)) begin
                        age_q[index][w] <= age_q[index][w] + 1'b1;
                    end
                end
                if (touch_way[w]) begin
                    if (fill) begin
                        valid_q[index][w] <= 1'b1;
                        dirty_q[index][w] <= 1'b0;
                    end else if (set_dirty) begin
                        dirty_q[index][w] <= 1'b1;
                    end
                end
            end
        end
    end

    assign valid = valid_q[index];
    assign dirty = dirty_q[index];
    assign ages = age_q[index];

endmodule

`default_nettype wire

// ==== source/cache_tag_store.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_tag_store (
    input  logic                                clk,
    input  logic                                rst_n,
    input  cache_pkg::index_t                   index,
    input  cache_pkg::tag_t                     tag_in,
    input  logic                                tag_we,
    input  cache_pkg::way_t                     tag_way,
    input  logic [`CACHE_WAYS-1:0]              valid,
    output cache_pkg::way_t                     hits,
    output cache_pkg::tag_t [`CACHE_WAYS-1:0]   tags_out
);

    cache_pkg::tag_t tags [`CACHE_SETS][`CACHE_WAYS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    tags[s][w] <= '0;
                end
            end
        end else if (tag_we) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (tag_way[w]) begin
                    tags[index][w] <= tag_in;
                end
            end
        end
    end

    // parallel compare, only valid ways can hit
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            tags_out[w] = tags[index][w];
            hits[w] = valid[w] && (tags[index][w] == tag_in);
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_pkg.sv ====
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

    typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] index_t;

    // one-hot over the ways, for hits and victim
    typedef logic [`CACHE_WAYS-1:0] way_t;

    typedef logic [`CACHE_LINE_BITS-1:0] line_t;
    typedef logic [`CACHE_LINE_BITS-1:0] mask_t;
    typedef logic [`CACHE_ADDR_BITS-1:0] addr_t;

    // 0 is most recently used
    typedef logic [$clog2(`CACHE_WAYS)-1:0] age_t;

endpackage

`default_nettype wire

// ==== source/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 4
`define CACHE_LINE_BITS 128

// address split: tag | index | offset
`define CACHE_TAG_BITS 8
`define CACHE_INDEX_BITS 2
`define CACHE_ADDR_BITS 15
`define CACHE_INDEX_LSB 5
`define CACHE_TAG_LSB 7

`endif
